/* common/icache_settings.svh */
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

//////////////////////////////
// cache geometry
//////////////////////////////

// set index bits, 16 sets
`define ICACHE_INDEX_WIDTH 4

// word in line bits, 4 words per line
`define ICACHE_OFFSET_WIDTH 2

// byte address width
`define ICACHE_ADDR_WIDTH 32

`endif

/* common/icache_pkg.sv */
`include "icache_settings.svh"

package icache_pkg;

    // one instruction or one address
    typedef logic [`ICACHE_ADDR_WIDTH-1:0] word_t;

    // low half is the addressed instruction
    typedef logic [2*`ICACHE_ADDR_WIDTH-1:0] pair_t;

    // a whole line of words
    typedef logic [(`ICACHE_ADDR_WIDTH << `ICACHE_OFFSET_WIDTH)-1:0] line_t;

    typedef logic [`ICACHE_INDEX_WIDTH-1:0] index_t;
    typedef logic [`ICACHE_OFFSET_WIDTH-1:0] offset_t;

    // address bits above index, offset and byte
    typedef logic [`ICACHE_ADDR_WIDTH-2-`ICACHE_INDEX_WIDTH-`ICACHE_OFFSET_WIDTH-1:0] tag_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_respond,
        st_refill_req,
        st_refill_wait,
        st_fill,
        st_inval,
        st_done
    } ctrl_state_t;

endpackage

/* common/icache_array_if.sv */
`timescale 1ns/1ps

interface icache_array_if;

    // lookup address, held by the controller
    icache_pkg::index_t lookup_index;
    icache_pkg::tag_t   lookup_tag;

    // write side
    logic               fill_en;
    icache_pkg::line_t  fill_line;
    logic               inval_en;
    logic               touch_en;

    // read results, one cycle after the index
    logic               hit;
    icache_pkg::line_t  hit_line;

    modport ctrl (
        output lookup_index, lookup_tag,
        output fill_en, fill_line, inval_en, touch_en,
        input  hit, hit_line
    );

    modport store (
        input  lookup_index, lookup_tag,
        input  fill_en, fill_line, inval_en, touch_en,
        output hit, hit_line
    );

endinterface

/* icache/icache_ctrl.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_ctrl (
    input  logic                clk,
    input  logic                reset,

    // fetch side
    input  logic                fetch_req,
    input  icache_pkg::word_t   fetch_addr,
    input  logic                fetch_op,
    output logic                fetch_ack,
    output icache_pkg::pair_t   fetch_instr,
    output logic                fetch_pair_valid,

    // memory side
    output logic                mem_req,
    output icache_pkg::word_t   mem_addr,
    input  logic                mem_ack,
    input  icache_pkg::line_t   mem_line,

    icache_array_if.ctrl        arr
);

    localparam int OFF_LO    = 2;
    localparam int IDX_LO    = OFF_LO + `ICACHE_OFFSET_WIDTH;
    localparam int TAG_LO    = IDX_LO + `ICACHE_INDEX_WIDTH;
    localparam int WORDS     = 1 << `ICACHE_OFFSET_WIDTH;
    localparam int WORD_BITS = $bits(icache_pkg::word_t);

    icache_pkg::ctrl_state_t state;

    // request buffer
    icache_pkg::word_t   rbuf_addr;
    icache_pkg::offset_t rbuf_offset;

    // line captured from memory
    icache_pkg::line_t   refill_line;

    // pair select
    icache_pkg::line_t   sel_line;
    icache_pkg::word_t   line_words [WORDS];
    icache_pkg::word_t   sel_lo;
    icache_pkg::word_t   sel_hi;
    logic                sel_valid;
    icache_pkg::pair_t   sel_pair;
    logic                result_load;

    assign rbuf_offset = rbuf_addr[IDX_LO-1:OFF_LO];

    //////////////////////////////
    // array requests
    //////////////////////////////

    assign arr.lookup_index = rbuf_addr[TAG_LO-1:IDX_LO];
    assign arr.lookup_tag   = rbuf_addr[`ICACHE_ADDR_WIDTH-1:TAG_LO];
    assign arr.fill_line    = refill_line;

    // fill once memory has released its ack
    assign arr.fill_en  = (state == icache_pkg::st_fill) && !mem_ack;
    assign arr.inval_en = (state == icache_pkg::st_inval);
    assign arr.touch_en = (state == icache_pkg::st_respond) && arr.hit;

    //////////////////////////////
    // instruction pair
    //////////////////////////////

    // hit line on the lookup path, captured line after a refill
    always_comb begin
        sel_line = (state == icache_pkg::st_fill) ? refill_line : arr.hit_line;
        for (int i = 0; i < WORDS; i++) begin
            line_words[i] = sel_line[i*WORD_BITS +: WORD_BITS];
        end
        sel_lo = line_words[rbuf_offset];
        if (!rbuf_offset[0]) begin
            // even offset, next word shares the aligned pair
            sel_hi    = line_words[{rbuf_offset[`ICACHE_OFFSET_WIDTH-1:1], 1'b1}];
            sel_valid = 1'b1;
        end else begin
            sel_hi    = '0;
            sel_valid = 1'b0;
        end
        sel_pair = {sel_hi, sel_lo};
    end

    assign result_load = ((state == icache_pkg::st_respond) && arr.hit) ||
                         ((state == icache_pkg::st_fill) && !mem_ack);

    //////////////////////////////
    // control fsm
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= icache_pkg::st_idle;
            fetch_ack <= 1'b0;
            mem_req   <= 1'b0;
        end else begin
            case (state)
                icache_pkg::st_idle: begin
                    if (fetch_req) begin
                        state <= fetch_op ? icache_pkg::st_inval : icache_pkg::st_lookup;
                    end
                end
                // array read in flight
                icache_pkg::st_lookup: begin
                    state <= icache_pkg::st_respond;
                end
                icache_pkg::st_respond: begin
                    if (arr.hit) begin
                        fetch_ack <= 1'b1;
                        state     <= icache_pkg::st_done;
                    end else begin
                        state <= icache_pkg::st_refill_req;
                    end
                end
                icache_pkg::st_refill_req: begin
                    mem_req <= 1'b1;
                    state   <= icache_pkg::st_refill_wait;
                end
                icache_pkg::st_refill_wait: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= icache_pkg::st_fill;
                    end
                end
                // close the memory handshake before the write
                icache_pkg::st_fill: begin
                    if (!mem_ack) begin
                        fetch_ack <= 1'b1;
                        state     <= icache_pkg::st_done;
                    end
                end
                icache_pkg::st_inval: begin
                    fetch_ack <= 1'b1;
                    state     <= icache_pkg::st_done;
                end
                // result held until the requester lets go
                icache_pkg::st_done: begin
                    if (!fetch_req) begin
                        fetch_ack <= 1'b0;
                        state     <= icache_pkg::st_idle;
                    end
                end
                default: begin
                    state <= icache_pkg::st_idle;
                end
            endcase
        end
    end

    //////////////////////////////
    // payload registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if ((state == icache_pkg::st_idle) && fetch_req) begin
            rbuf_addr <= fetch_addr;
            // line aligned, offset and byte bits cleared
            mem_addr  <= {fetch_addr[`ICACHE_ADDR_WIDTH-1:IDX_LO], {IDX_LO{1'b0}}};
        end
        if ((state == icache_pkg::st_refill_wait) && mem_ack) begin
            refill_line <= mem_line;
        end
        if (result_load) begin
            fetch_instr      <= sel_pair;
            fetch_pair_valid <= sel_valid;
        end else if (state == icache_pkg::st_inval) begin
            fetch_instr      <= '0;
            fetch_pair_valid <= 1'b0;
        end
    end

endmodule

/* icache/icache_store.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_store (
    input  logic          clk,
    input  logic          reset,
    icache_array_if.store arr
);

    localparam int SETS = 1 << `ICACHE_INDEX_WIDTH;

    // storage, first index is the way
    icache_pkg::tag_t  tag_mem  [0:1][0:SETS-1];
    icache_pkg::line_t data_mem [0:1][0:SETS-1];
    logic [1:0]        valid_bits [0:SETS-1];

    // one bit per set, names the least recently used way
    logic [SETS-1:0]   lru_bits;

    // registered read port
    icache_pkg::tag_t  rd_tag  [0:1];
    icache_pkg::line_t rd_line [0:1];
    logic [1:0]        rd_valid;
    icache_pkg::tag_t  cmp_tag;

    logic [1:0]        way_hit;
    logic [1:0]        set_valid;
    logic              victim;

    //////////////////////////////
    // read and compare
    //////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            rd_tag[w]  <= tag_mem[w][arr.lookup_index];
            rd_line[w] <= data_mem[w][arr.lookup_index];
        end
        rd_valid <= valid_bits[arr.lookup_index];
        cmp_tag  <= arr.lookup_tag;
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = rd_valid[w] && (rd_tag[w] == cmp_tag);
        end
    end

    assign arr.hit      = |way_hit;
    assign arr.hit_line = way_hit[1] ? rd_line[1] : rd_line[0];

    //////////////////////////////
    // victim choice
    //////////////////////////////

    assign set_valid = valid_bits[arr.lookup_index];

    // an empty way first, lru way otherwise
    always_comb begin
        if (!set_valid[0]) begin
            victim = 1'b0;
        end else if (!set_valid[1]) begin
            victim = 1'b1;
        end else begin
            victim = lru_bits[arr.lookup_index];
        end
    end

    //////////////////////////////
    // array writes
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (arr.fill_en) begin
            tag_mem[victim][arr.lookup_index]  <= arr.lookup_tag;
            data_mem[victim][arr.lookup_index] <= arr.fill_line;
        end
    end

    // valid and lru state
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < SETS; s++) begin
                valid_bits[s] <= 2'b00;
            end
            lru_bits <= '0;
        end else if (arr.inval_en) begin
            valid_bits[arr.lookup_index] <= 2'b00;
        end else if (arr.fill_en) begin
            valid_bits[arr.lookup_index][victim] <= 1'b1;
            // the other way becomes lru
            lru_bits[arr.lookup_index] <= ~victim;
        end else if (arr.touch_en) begin
            lru_bits[arr.lookup_index] <= ~way_hit[1];
        end
    end

endmodule

/* design/icache.sv */
`timescale 1ns/1ps

module icache (
    input  logic               clk,
    input  logic               reset,

    // fetch port
    input  logic               fetch_req,
    input  icache_pkg::word_t  fetch_addr,
    input  logic               fetch_op,
    output logic               fetch_ack,
    output icache_pkg::pair_t  fetch_instr,
    output logic               fetch_pair_valid,

    // memory refill port
    output logic               mem_req,
    output icache_pkg::word_t  mem_addr,
    input  logic               mem_ack,
    input  icache_pkg::line_t  mem_line
);

    //////////////////////////////
    // controller to storage link
    //////////////////////////////

    icache_array_if arr_if ();

    //////////////////////////////
    // request and handshake fsm
    //////////////////////////////

    icache_ctrl ctrl_inst (
        .clk              (clk),
        .reset            (reset),
        .fetch_req        (fetch_req),
        .fetch_addr       (fetch_addr),
        .fetch_op         (fetch_op),
        .fetch_ack        (fetch_ack),
        .fetch_instr      (fetch_instr),
        .fetch_pair_valid (fetch_pair_valid),
        .mem_req          (mem_req),
        .mem_addr         (mem_addr),
        .mem_ack          (mem_ack),
        .mem_line         (mem_line),
        .arr              (arr_if.ctrl)
    );

    //////////////////////////////
    // tag, data and lru arrays
    //////////////////////////////

    // two ways, hit and victim decided here
    icache_store store_inst (
        .clk   (clk),
        .reset (reset),
        .arr   (arr_if.store)
    );

endmodule

/* tb/icache_mem_model.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_mem_model #(
    parameter int unsigned SEED = 32'h0aa5a623
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              mem_req,
    input  icache_pkg::word_t mem_addr,
    output logic              mem_ack,
    output icache_pkg::line_t mem_line,
    output int                refill_count
);

    localparam int WORDS = 1 << `ICACHE_OFFSET_WIDTH;

    // each word is its own byte address xor a fixed mask
    function automatic icache_pkg::line_t line_pattern(icache_pkg::word_t base);
        icache_pkg::line_t line;
        icache_pkg::word_t addr;
        for (int i = 0; i < WORDS; i++) begin
            addr = base + 4 * i;
            line[i*32 +: 32] = addr ^ 32'h5a5a0000;
        end
        return line;
    endfunction

    //////////////////////////////
    // four-phase responder
    //////////////////////////////

    initial begin
        int unsigned delay;
        mem_ack      = 1'b0;
        mem_line     = '0;
        refill_count = 0;
        void'($urandom(SEED));
        forever begin
            @(posedge clk);
            #1;
            if (!reset && mem_req === 1'b1) begin
                // answer 1 to 4 cycles after the request
                delay = 1 + ($urandom % 4);
                for (int c = 1; c < delay; c++) begin
                    @(posedge clk);
                    #1;
                end
                mem_line     = line_pattern(mem_addr);
                mem_ack      = 1'b1;
                refill_count = refill_count + 1;
                do begin
                    @(posedge clk);
                    #1;
                end while (mem_req === 1'b1);
                mem_ack = 1'b0;
            end
        end
    end

endmodule

/* tb/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb;

    localparam int NUM_FETCHES = 29;
    localparam int FETCH_WORST = 20;
    localparam int HOLD_TOTAL  = 20;
    localparam int MAX_CYCLES  = NUM_FETCHES * FETCH_WORST + HOLD_TOTAL + 1400;

    logic              clk = 1'b0;
    logic              reset = 1'b1;
    logic              fetch_req = 1'b0;
    icache_pkg::word_t fetch_addr = '0;
    logic              fetch_op = 1'b0;
    logic              fetch_ack;
    icache_pkg::pair_t fetch_instr;
    logic              fetch_pair_valid;
    logic              mem_req;
    icache_pkg::word_t mem_addr;
    logic              mem_ack;
    icache_pkg::line_t mem_line;
    int                refill_count;

    int value_errors = 0;
    int other_errors = 0;
    int cycle_count = 0;

    icache icache_inst (
        .clk              (clk),
        .reset            (reset),
        .fetch_req        (fetch_req),
        .fetch_addr       (fetch_addr),
        .fetch_op         (fetch_op),
        .fetch_ack        (fetch_ack),
        .fetch_instr      (fetch_instr),
        .fetch_pair_valid (fetch_pair_valid),
        .mem_req          (mem_req),
        .mem_addr         (mem_addr),
        .mem_ack          (mem_ack),
        .mem_line         (mem_line)
    );

    icache_mem_model #(.SEED(32'h0aa5a623)) mem_model_inst (
        .clk          (clk),
        .reset        (reset),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_ack      (mem_ack),
        .mem_line     (mem_line),
        .refill_count (refill_count)
    );

    always #10 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the cache stopped answering", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // expected values
    //////////////////////////////

    function automatic icache_pkg::word_t model_word(icache_pkg::word_t addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a0000;
    endfunction

    // high half only when the next word shares the aligned pair
    function automatic icache_pkg::pair_t expected_pair(icache_pkg::word_t addr);
        if (addr[2] == 1'b0) begin
            return {model_word(addr + 4), model_word(addr)};
        end
        return {32'h0, model_word(addr)};
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("Error %s: expected %h, actual %h", name, expected, actual);
        value_errors = value_errors + 1;
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        other_errors = other_errors + 1;
    endtask

    //////////////////////////////
    // one full fetch handshake
    //////////////////////////////

    // entered and left 1 ns after a rising edge, with fetch_ack low
    task automatic run_fetch(input icache_pkg::word_t addr, input logic op, input int hold,
                             output icache_pkg::pair_t instr, output logic pv,
                             output int edges);
        fetch_addr = addr;
        fetch_op   = op;
        fetch_req  = 1'b1;
        edges      = 0;
        do begin
            @(posedge clk);
            #1;
            edges = edges + 1;
        end while (fetch_ack !== 1'b1);
        instr = fetch_instr;
        pv    = fetch_pair_valid;
        repeat (hold) begin
            @(posedge clk);
            #1;
            if (fetch_ack !== 1'b1 || fetch_instr !== instr || fetch_pair_valid !== pv) begin
                report_problem("fetch result changed while fetch_req was held high");
            end
        end
        fetch_req = 1'b0;
        fetch_op  = 1'b0;
        @(posedge clk);
        #1;
        if (fetch_ack !== 1'b0) begin
            report_problem("fetch_ack did not drop one cycle after fetch_req");
        end
        while (fetch_ack !== 1'b0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic fetch_and_check(input string name, input icache_pkg::word_t addr,
                                   input int exp_refills, input int hold, output int edges);
        icache_pkg::pair_t instr;
        logic              pv;
        int                refills_before;
        refills_before = refill_count;
        run_fetch(addr, 1'b0, hold, instr, pv, edges);
        if (instr !== expected_pair(addr)) begin
            report_mismatch(name, expected_pair(addr), instr);
        end
        if (pv !== !addr[2]) begin
            report_mismatch({name, " pair_valid"}, !addr[2], pv);
        end
        if (refill_count - refills_before != exp_refills) begin
            report_mismatch({name, " refills"}, exp_refills, refill_count - refills_before);
        end
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic cold_miss_then_hit();
        int edges;
        fetch_and_check("cold miss", 32'h0000_1040, 1, 0, edges);
        fetch_and_check("repeat hit", 32'h0000_1040, 0, 0, edges);
        if (edges != 3) begin
            report_mismatch("repeat hit latency", 3, edges);
        end
    endtask

    task automatic pair_rule_offsets();
        int edges;
        fetch_and_check("pair offset 0", 32'h0000_2080, 1, 0, edges);
        fetch_and_check("pair offset 1", 32'h0000_2084, 0, 0, edges);
        fetch_and_check("pair offset 2", 32'h0000_2088, 0, 0, edges);
        fetch_and_check("pair offset 3", 32'h0000_208c, 0, 0, edges);
    endtask

    // three tags in set 2, two ways
    task automatic lru_replacement();
        int edges;
        fetch_and_check("replace fill a", 32'h0001_0020, 1, 0, edges);
        fetch_and_check("replace fill b", 32'h0002_0020, 1, 0, edges);
        fetch_and_check("replace hit a", 32'h0001_0020, 0, 0, edges);
        fetch_and_check("replace hit b", 32'h0002_0020, 0, 0, edges);
        fetch_and_check("replace touch a", 32'h0001_0020, 0, 0, edges);
        fetch_and_check("replace fill c", 32'h0003_0020, 1, 0, edges);
        fetch_and_check("replace a kept", 32'h0001_0020, 0, 0, edges);
        fetch_and_check("replace b evicted", 32'h0002_0020, 1, 0, edges);
    endtask

    task automatic set_invalidation();
        icache_pkg::pair_t instr;
        logic              pv;
        int                edges;
        int                refills_before;
        fetch_and_check("inval fill d", 32'h0004_0050, 1, 0, edges);
        fetch_and_check("inval fill e", 32'h0005_0050, 1, 0, edges);
        fetch_and_check("inval fill f", 32'h0004_0060, 1, 0, edges);
        refills_before = refill_count;
        run_fetch(32'h0004_0050, 1'b1, 0, instr, pv, edges);
        if (instr !== '0) begin
            report_mismatch("inval result", 64'h0, instr);
        end
        if (pv !== 1'b0) begin
            report_mismatch("inval pair_valid", 0, pv);
        end
        if (edges != 2) begin
            report_mismatch("inval latency", 2, edges);
        end
        if (refill_count != refills_before) begin
            report_problem("set invalidation started a memory refill");
        end
        fetch_and_check("inval other set", 32'h0004_0060, 0, 0, edges);
        fetch_and_check("inval refill d", 32'h0004_0050, 1, 0, edges);
        fetch_and_check("inval refill e", 32'h0005_0050, 1, 0, edges);
    endtask

    task automatic back_pressure_hold();
        int edges;
        fetch_and_check("held miss", 32'h0007_00a8, 1, 10, edges);
        fetch_and_check("held hit", 32'h0007_00a8, 0, 10, edges);
        // new tags each time, so every fetch sees a fresh memory delay
        for (int i = 0; i < 6; i++) begin
            fetch_and_check("random delay miss", 32'h0010_00c4 + i * 32'h100, 1, 0, edges);
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        if (fetch_ack !== 1'b0 || mem_req !== 1'b0) begin
            report_problem("fetch_ack or mem_req not low after reset");
        end
        cold_miss_then_hit();
        pair_rule_offsets();
        lru_replacement();
        set_invalidation();
        back_pressure_hold();
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+common
common/icache_pkg.sv
common/icache_array_if.sv
icache/icache_ctrl.sv
icache/icache_store.sv
design/icache.sv
tb/icache_mem_model.sv
tb/icache_tb.sv
